//--- src/ctrl_pkg.sv
package ctrl_pkg;

  localparam int XLEN_INST  = 32;
  localparam int REG_ADDR_W = 5;
  localparam int ECODE_W    = 4;

  // Base opcodes, SYSTEM left out on purpose
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_LUI      = 7'b0110111;

  localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
  localparam logic [2:0] FUNCT3_BNE  = 3'b001;
  localparam logic [2:0] FUNCT3_BLT  = 3'b100;
  localparam logic [2:0] FUNCT3_BGE  = 3'b101;
  localparam logic [2:0] FUNCT3_BLTU = 3'b110;
  localparam logic [2:0] FUNCT3_BGEU = 3'b111;

  localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
  localparam logic [2:0] FUNCT3_SLL     = 3'b001;
  localparam logic [2:0] FUNCT3_SLT     = 3'b010;
  localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
  localparam logic [2:0] FUNCT3_XOR     = 3'b100;
  localparam logic [2:0] FUNCT3_SRA_SRL = 3'b101;
  localparam logic [2:0] FUNCT3_OR      = 3'b110;
  localparam logic [2:0] FUNCT3_AND     = 3'b111;

  localparam logic [2:0] FUNCT3_FENCE = 3'b000;

  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;  // SUB and SRA

  localparam logic [ECODE_W-1:0] ECODE_ILLEGAL_INST = 4'd2;

  typedef enum logic [3:0] {
    ALU_OP_ADD, ALU_OP_SUB, ALU_OP_SLL, ALU_OP_SLT, ALU_OP_SLTU,
    ALU_OP_XOR, ALU_OP_SRL, ALU_OP_SRA, ALU_OP_OR, ALU_OP_AND,
    ALU_OP_SEQ, ALU_OP_SNE, ALU_OP_SGE, ALU_OP_SGEU, ALU_OP_SRCB
  } alu_op_t;

  typedef enum logic [1:0] {IMM_I, IMM_S, IMM_U, IMM_J} imm_type_t;

  typedef enum logic {SRC_A_RS1, SRC_A_PC} src_a_sel_t;

  typedef enum logic [1:0] {SRC_B_RS2, SRC_B_IMM, SRC_B_FOUR} src_b_sel_t;

  typedef enum logic [1:0] {WB_SRC_ALU, WB_SRC_MEM, WB_SRC_MALU} wb_src_sel_t;

  typedef enum logic [2:0] {
    PC_PLUS_FOUR, PC_BRANCH_TARGET, PC_JAL_TARGET, PC_JALR_TARGET, PC_HANDLER
  } pc_src_sel_t;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]           imm12;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } instr_t;

endpackage

//--- src/id_ctrl_if.sv
`timescale 1ns/1ps

interface id_ctrl_if
  import ctrl_pkg::*;
();

  alu_op_t               alu_op;
  src_a_sel_t            src_a_sel;
  src_b_sel_t            src_b_sel;
  wb_src_sel_t           wb_src_sel;
  logic [2:0]            dmem_size;
  logic [2:0]            dmem_type;
  logic                  branch_op;
  logic                  jal;
  logic                  jalr;
  logic                  dmem_en;
  logic                  dmem_wen;
  logic                  wr_reg;
  logic                  illegal;
  logic [REG_ADDR_W-1:0] rd;
  logic [REG_ADDR_W-1:0] rs1;       // Hazard compare only
  logic [REG_ADDR_W-1:0] rs2;
  logic                  uses_rs1;
  logic                  uses_rs2;

  modport decoder (
    output alu_op, src_a_sel, src_b_sel, wb_src_sel, dmem_size, dmem_type,
           branch_op, jal, jalr, dmem_en, dmem_wen, wr_reg, illegal,
           rd, rs1, rs2, uses_rs1, uses_rs2
  );

  modport stage (
    input alu_op, src_a_sel, src_b_sel, wb_src_sel, dmem_size, dmem_type,
          branch_op, jal, jalr, dmem_en, dmem_wen, wr_reg, illegal, rd
  );

endinterface

//--- src/ex_ctrl_if.sv
`timescale 1ns/1ps

interface ex_ctrl_if
  import ctrl_pkg::*;
();

  logic                  valid;
  alu_op_t               alu_op;
  src_a_sel_t            src_a_sel;
  src_b_sel_t            src_b_sel;
  wb_src_sel_t           wb_src_sel;
  logic                  branch_op;
  logic                  jal;
  logic                  jalr;
  logic                  dmem_en;
  logic                  dmem_wen;
  logic [2:0]            dmem_size;
  logic [2:0]            dmem_type;
  logic                  wr_reg;
  logic                  illegal;
  logic [REG_ADDR_W-1:0] rd;

  // Back from the EX/WB controller
  logic                  stall_ex;
  logic                  kill_id;

  modport stage (
    output valid, alu_op, src_a_sel, src_b_sel, wb_src_sel, branch_op, jal, jalr,
           dmem_en, dmem_wen, dmem_size, dmem_type, wr_reg, illegal, rd,
    input  stall_ex, kill_id
  );

  modport control (
    input  valid, alu_op, src_a_sel, src_b_sel, wb_src_sel, branch_op, jal, jalr,
           dmem_en, dmem_wen, dmem_size, dmem_type, wr_reg, illegal, rd,
    output stall_ex, kill_id
  );

endinterface

//--- src/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
  import ctrl_pkg::*;
(
  input  instr_t     inst,
  id_ctrl_if.decoder ctrl,
  output imm_type_t  imm_type
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       is_slt;
  alu_op_t    srl_or_sra;
  alu_op_t    alu_op_arith;

  assign opcode = inst.r_fmt.opcode;
  assign funct3 = inst.r_fmt.funct3;
  assign is_slt = (funct3 == FUNCT3_SLT) || (funct3 == FUNCT3_SLTU);

  assign ctrl.rd        = inst.r_fmt.rd;
  assign ctrl.rs1       = inst.r_fmt.rs1;
  assign ctrl.rs2       = inst.r_fmt.rs2;
  assign ctrl.dmem_size = {1'b0, funct3[1:0]};
  assign ctrl.dmem_type = funct3;  // Bit 2 marks unsigned loads

  assign srl_or_sra = (inst.r_fmt.funct7 == FUNCT7_ALT) ? ALU_OP_SRA : ALU_OP_SRL;

  always_comb begin
    case (funct3)
      FUNCT3_ADD_SUB: alu_op_arith = ALU_OP_ADD;
      FUNCT3_SLL:     alu_op_arith = ALU_OP_SLL;
      FUNCT3_SLT:     alu_op_arith = ALU_OP_SLT;
      FUNCT3_SLTU:    alu_op_arith = ALU_OP_SLTU;
      FUNCT3_XOR:     alu_op_arith = ALU_OP_XOR;
      FUNCT3_SRA_SRL: alu_op_arith = srl_or_sra;
      FUNCT3_OR:      alu_op_arith = ALU_OP_OR;
      default:        alu_op_arith = ALU_OP_AND;
    endcase
  end

  always_comb begin
    ctrl.alu_op     = ALU_OP_SRCB;
    ctrl.src_a_sel  = SRC_A_RS1;
    ctrl.src_b_sel  = SRC_B_IMM;
    ctrl.wb_src_sel = WB_SRC_MALU;
    ctrl.branch_op  = 1'b0;
    ctrl.jal        = 1'b0;
    ctrl.jalr       = 1'b0;
    ctrl.dmem_en    = 1'b0;
    ctrl.dmem_wen   = 1'b0;
    ctrl.wr_reg     = 1'b0;
    ctrl.illegal    = 1'b0;
    ctrl.uses_rs1   = 1'b1;
    ctrl.uses_rs2   = 1'b0;
    imm_type        = IMM_I;
    case (opcode)
      OPC_LOAD: begin
        ctrl.alu_op     = ALU_OP_ADD;  // Address offset
        ctrl.dmem_en    = 1'b1;
        ctrl.wr_reg     = 1'b1;
        ctrl.wb_src_sel = WB_SRC_MEM;
      end
      OPC_STORE: begin
        ctrl.alu_op   = ALU_OP_ADD;
        ctrl.uses_rs2 = 1'b1;
        ctrl.dmem_en  = 1'b1;
        ctrl.dmem_wen = 1'b1;
        imm_type      = IMM_S;
      end
      OPC_BRANCH: begin
        ctrl.uses_rs2  = 1'b1;
        ctrl.src_b_sel = SRC_B_RS2;
        ctrl.branch_op = 1'b1;
        case (funct3)
          FUNCT3_BEQ:  ctrl.alu_op = ALU_OP_SEQ;
          FUNCT3_BNE:  ctrl.alu_op = ALU_OP_SNE;
          FUNCT3_BLT:  ctrl.alu_op = ALU_OP_SLT;
          FUNCT3_BGE:  ctrl.alu_op = ALU_OP_SGE;
          FUNCT3_BLTU: ctrl.alu_op = ALU_OP_SLTU;
          FUNCT3_BGEU: ctrl.alu_op = ALU_OP_SGEU;
          default:     ctrl.illegal = 1'b1;
        endcase
      end
      OPC_JAL, OPC_JALR: begin
        // Link value is PC + 4
        ctrl.alu_op     = ALU_OP_ADD;
        ctrl.src_a_sel  = SRC_A_PC;
        ctrl.src_b_sel  = SRC_B_FOUR;
        ctrl.wb_src_sel = WB_SRC_ALU;
        ctrl.wr_reg     = 1'b1;
        if (opcode == OPC_JAL) begin
          ctrl.jal      = 1'b1;
          ctrl.uses_rs1 = 1'b0;
          imm_type      = IMM_J;
        end else begin
          ctrl.jalr    = 1'b1;
          ctrl.illegal = (inst.i_fmt.funct3 != 3'b000);
        end
      end
      OPC_MISC_MEM: begin
        // Plain FENCE is a no-op here
        ctrl.illegal = (inst.i_fmt.funct3 != FUNCT3_FENCE) ||
                       (inst.i_fmt.imm12[11:8] != 4'b0000) ||
                       (inst.i_fmt.rs1 != '0) || (inst.i_fmt.rd != '0);
      end
      OPC_OP_IMM: begin
        ctrl.wr_reg = 1'b1;
        ctrl.alu_op = alu_op_arith;
        if (is_slt)
          ctrl.wb_src_sel = WB_SRC_ALU;
        if ((funct3 == FUNCT3_ADD_SUB) &&
            ((inst.r_fmt.rs1 == '0) || (inst.i_fmt.imm12 == '0)))
          ctrl.alu_op = ALU_OP_XOR;  // Move or load immediate
      end
      OPC_OP: begin
        ctrl.uses_rs2  = 1'b1;
        ctrl.src_b_sel = SRC_B_RS2;
        ctrl.wr_reg    = 1'b1;
        ctrl.alu_op    = alu_op_arith;
        if (is_slt)
          ctrl.wb_src_sel = WB_SRC_ALU;
        if ((funct3 == FUNCT3_ADD_SUB) && (inst.r_fmt.funct7 == FUNCT7_ALT))
          ctrl.alu_op = ALU_OP_SUB;
      end
      OPC_AUIPC: begin
        ctrl.alu_op     = ALU_OP_ADD;
        ctrl.uses_rs1   = 1'b0;
        ctrl.src_a_sel  = SRC_A_PC;
        ctrl.wb_src_sel = WB_SRC_ALU;
        ctrl.wr_reg     = 1'b1;
        imm_type        = IMM_U;
      end
      OPC_LUI: begin
        ctrl.uses_rs1 = 1'b0;  // Immediate passes through
        ctrl.wr_reg   = 1'b1;
        imm_type      = IMM_U;
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

endmodule

//--- src/id_ex_ctrl_reg.sv
`timescale 1ns/1ps

module id_ex_ctrl_reg
  import ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  id_ctrl_if.stage id,
  ex_ctrl_if.stage ex
);

  logic load;

  assign load = !ex.stall_ex && !ex.kill_id;

  // Flags drop to a bubble on kill
  always_ff @(posedge clk) begin
    if (reset) begin
      ex.valid     <= 1'b0;
      ex.branch_op <= 1'b0;
      ex.jal       <= 1'b0;
      ex.jalr      <= 1'b0;
      ex.dmem_en   <= 1'b0;
      ex.dmem_wen  <= 1'b0;
      ex.wr_reg    <= 1'b0;
      ex.illegal   <= 1'b0;
    end else if (!ex.stall_ex) begin
      ex.valid     <= !ex.kill_id;
      ex.branch_op <= id.branch_op && !ex.kill_id;
      ex.jal       <= id.jal && !ex.kill_id;
      ex.jalr      <= id.jalr && !ex.kill_id;
      ex.dmem_en   <= id.dmem_en && !ex.kill_id;
      ex.dmem_wen  <= id.dmem_wen && !ex.kill_id;
      ex.wr_reg    <= id.wr_reg && !ex.kill_id;
      ex.illegal   <= id.illegal && !ex.kill_id;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      ex.alu_op     <= id.alu_op;
      ex.src_a_sel  <= id.src_a_sel;
      ex.src_b_sel  <= id.src_b_sel;
      ex.wb_src_sel <= id.wb_src_sel;
      ex.dmem_size  <= id.dmem_size;
      ex.dmem_type  <= id.dmem_type;
      ex.rd         <= id.rd;
    end
  end

endmodule

//--- src/ex_wb_ctrl.sv
`timescale 1ns/1ps

module ex_wb_ctrl
  import ctrl_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  ex_ctrl_if.control            ex,
  input  logic [REG_ADDR_W-1:0] rs1,
  input  logic [REG_ADDR_W-1:0] rs2,
  input  logic                  uses_rs1,
  input  logic                  uses_rs2,
  input  logic                  cmp_true,
  input  logic                  dmem_wait,
  output pc_src_sel_t           pc_src_sel,
  output logic                  stall_id,
  output logic                  bypass_rs1,
  output logic                  bypass_rs2,
  output logic                  dmem_en,
  output logic                  dmem_wen,
  output logic                  wr_reg_wb,
  output logic                  exception_wb,
  output logic                  retire_wb,
  output logic [REG_ADDR_W-1:0] reg_to_wr_wb,
  output wb_src_sel_t           wb_src_sel_wb,
  output logic [ECODE_W-1:0]    exception_code_wb
);

  logic stall_wb;
  logic ex_ex;
  logic kill_ex;
  logic branch_taken;
  logic jal;
  logic jalr;
  logic redirect;
  logic wr_reg_ex;
  logic wait_rs1;
  logic wait_rs2;
  logic valid_wb;
  logic wr_reg_unkilled_wb;
  logic dmem_en_wb;

  assign stall_wb    = dmem_wait && dmem_en_wb;
  assign ex.stall_ex = stall_wb;

  assign ex_ex   = ex.valid && ex.illegal;
  assign kill_ex = stall_wb || ex_ex || exception_wb;

  assign branch_taken = ex.branch_op && cmp_true && !kill_ex;
  assign jal          = ex.jal && !kill_ex;
  assign jalr         = ex.jalr && !kill_ex;
  assign dmem_en      = ex.dmem_en && !kill_ex;
  assign dmem_wen     = ex.dmem_wen && !kill_ex;
  assign wr_reg_ex    = ex.wr_reg && !kill_ex;
  assign redirect     = branch_taken || jal || jalr;

  // RAW against EX has no bypass, so ID waits a cycle
  assign wait_rs1 = wr_reg_ex && uses_rs1 && (rs1 == ex.rd) && (rs1 != '0);
  assign wait_rs2 = wr_reg_ex && uses_rs2 && (rs2 == ex.rd) && (rs2 != '0);

  assign stall_id   = stall_wb || wait_rs1 || wait_rs2;
  assign ex.kill_id = stall_id || redirect || ex_ex || exception_wb;

  always_comb begin
    if (exception_wb)
      pc_src_sel = PC_HANDLER;
    else if (branch_taken)
      pc_src_sel = PC_BRANCH_TARGET;
    else if (jal)
      pc_src_sel = PC_JAL_TARGET;
    else if (jalr)
      pc_src_sel = PC_JALR_TARGET;
    else
      pc_src_sel = PC_PLUS_FOUR;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_wb           <= 1'b0;
      wr_reg_unkilled_wb <= 1'b0;
      dmem_en_wb         <= 1'b0;
      exception_wb       <= 1'b0;
    end else if (!stall_wb) begin
      valid_wb           <= ex.valid && !exception_wb;  // Younger than a trap
      wr_reg_unkilled_wb <= wr_reg_ex;
      dmem_en_wb         <= dmem_en;
      exception_wb       <= ex_ex && !exception_wb;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_wb) begin
      reg_to_wr_wb  <= ex.rd;
      wb_src_sel_wb <= ex.wb_src_sel;
    end
  end

  assign wr_reg_wb         = wr_reg_unkilled_wb && !stall_wb;
  assign retire_wb         = valid_wb && !stall_wb && !exception_wb;
  assign exception_code_wb = exception_wb ? ECODE_ILLEGAL_INST : '0;

  assign bypass_rs1 = wr_reg_wb && uses_rs1 && (rs1 == reg_to_wr_wb) && (rs1 != '0);
  assign bypass_rs2 = wr_reg_wb && uses_rs2 && (rs2 == reg_to_wr_wb) && (rs2 != '0);

endmodule

//--- src/pipeline_ctrl.sv
`timescale 1ns/1ps

module pipeline_ctrl
  import ctrl_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  instr_t                inst_id,
  input  logic                  dmem_wait,
  input  logic                  cmp_true,
  output pc_src_sel_t           pc_src_sel,
  output imm_type_t             imm_type_id,
  output logic                  bypass_rs1,
  output logic                  bypass_rs2,
  output logic                  stall_id,
  output logic                  kill_id,
  output src_a_sel_t            src_a_sel_ex,
  output src_b_sel_t            src_b_sel_ex,
  output alu_op_t               alu_op_ex,
  output logic                  dmem_en,
  output logic                  dmem_wen,
  output logic [2:0]            dmem_size,
  output logic [2:0]            dmem_type,
  output logic                  wr_reg_wb,
  output logic [REG_ADDR_W-1:0] reg_to_wr_wb,
  output wb_src_sel_t           wb_src_sel_wb,
  output logic                  exception_wb,
  output logic [ECODE_W-1:0]    exception_code_wb,
  output logic                  retire_wb
);

  id_ctrl_if id_bus ();
  ex_ctrl_if ex_bus ();

  instr_decoder u_decoder (
    .inst     (inst_id),
    .ctrl     (id_bus.decoder),
    .imm_type (imm_type_id)
  );

  id_ex_ctrl_reg u_id_ex (
    .clk   (clk),
    .reset (reset),
    .id    (id_bus.stage),
    .ex    (ex_bus.stage)
  );

  ex_wb_ctrl u_ex_wb (
    .clk               (clk),
    .reset             (reset),
    .ex                (ex_bus.control),
    .rs1               (id_bus.rs1),  // Straight from decode for the hazard compare
    .rs2               (id_bus.rs2),
    .uses_rs1          (id_bus.uses_rs1),
    .uses_rs2          (id_bus.uses_rs2),
    .cmp_true          (cmp_true),
    .dmem_wait         (dmem_wait),
    .pc_src_sel        (pc_src_sel),
    .stall_id          (stall_id),
    .bypass_rs1        (bypass_rs1),
    .bypass_rs2        (bypass_rs2),
    .dmem_en           (dmem_en),
    .dmem_wen          (dmem_wen),
    .wr_reg_wb         (wr_reg_wb),
    .exception_wb      (exception_wb),
    .retire_wb         (retire_wb),
    .reg_to_wr_wb      (reg_to_wr_wb),
    .wb_src_sel_wb     (wb_src_sel_wb),
    .exception_code_wb (exception_code_wb)
  );

  assign kill_id      = ex_bus.kill_id;
  assign src_a_sel_ex = ex_bus.src_a_sel;
  assign src_b_sel_ex = ex_bus.src_b_sel;
  assign alu_op_ex    = ex_bus.alu_op;
  assign dmem_size    = ex_bus.dmem_size;
  assign dmem_type    = ex_bus.dmem_type;

endmodule

//--- testbench/pipeline_ctrl_tb.sv
`timescale 1ns/1ps

module pipeline_ctrl_tb
  import ctrl_pkg::*;
();

  localparam int          ACCEPT_LIMIT = 20;
  localparam logic [4:0]  KILLED_RD    = 5'd31;  // Only younger, killed words use it
  localparam logic [31:0] NOP          = 32'h00000013;
  localparam logic [31:0] SYSTEM_WORD  = 32'h00000073;  // ECALL
  localparam logic [31:0] YOUNG        = {7'd0, 5'd18, 5'd17, 3'd0, KILLED_RD, OPC_OP};

  typedef struct packed {
    alu_op_t     alu_op;
    src_a_sel_t  src_a;
    src_b_sel_t  src_b;
    wb_src_sel_t wb_src;
    imm_type_t   imm;
    logic [2:0]  dsize;
    logic [2:0]  dtype;
    logic        branch;
    logic        jal;
    logic        jalr;
    logic        dmem_en;
    logic        dmem_wen;
    logic        wr_reg;
    logic        illegal;
    logic        uses_rs1;
    logic        uses_rs2;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
  } dec_t;

  logic                  clk;
  logic                  reset;
  instr_t                inst_id;
  logic                  dmem_wait;
  logic                  cmp_true;
  pc_src_sel_t           pc_src_sel;
  imm_type_t             imm_type_id;
  logic                  bypass_rs1;
  logic                  bypass_rs2;
  logic                  stall_id;
  logic                  kill_id;
  src_a_sel_t            src_a_sel_ex;
  src_b_sel_t            src_b_sel_ex;
  alu_op_t               alu_op_ex;
  logic                  dmem_en;
  logic                  dmem_wen;
  logic [2:0]            dmem_size;
  logic [2:0]            dmem_type;
  logic                  wr_reg_wb;
  logic [REG_ADDR_W-1:0] reg_to_wr_wb;
  wb_src_sel_t           wb_src_sel_wb;
  logic                  exception_wb;
  logic [ECODE_W-1:0]    exception_code_wb;
  logic                  retire_wb;

  int          errors;
  int          n_hazard, n_mem_stall, n_byp1, n_byp2;
  int          n_branch, n_jal, n_jalr, n_trap, n_retire;

  // Model pipeline state
  logic        ex_valid;
  dec_t        ex_d;
  logic        wb_valid, wb_wr, wb_dmem, wb_exc;
  logic [4:0]  wb_rd;
  wb_src_sel_t wb_src;

  // Model levels of the current cycle
  dec_t        id_d;
  logic        stall_wb_m, ex_exc_m, kill_ex_m, taken_m, jal_m, jalr_m, wr_ex_m;
  logic        hz1, hz2, exp_stall, exp_kill, exp_wr, exp_retire, exp_byp1, exp_byp2;
  pc_src_sel_t exp_pc;

  pipeline_ctrl UUT (
    .clk               (clk),
    .reset             (reset),
    .inst_id           (inst_id),
    .dmem_wait         (dmem_wait),
    .cmp_true          (cmp_true),
    .pc_src_sel        (pc_src_sel),
    .imm_type_id       (imm_type_id),
    .bypass_rs1        (bypass_rs1),
    .bypass_rs2        (bypass_rs2),
    .stall_id          (stall_id),
    .kill_id           (kill_id),
    .src_a_sel_ex      (src_a_sel_ex),
    .src_b_sel_ex      (src_b_sel_ex),
    .alu_op_ex         (alu_op_ex),
    .dmem_en           (dmem_en),
    .dmem_wen          (dmem_wen),
    .dmem_size         (dmem_size),
    .dmem_type         (dmem_type),
    .wr_reg_wb         (wr_reg_wb),
    .reg_to_wr_wb      (reg_to_wr_wb),
    .wb_src_sel_wb     (wb_src_sel_wb),
    .exception_wb      (exception_wb),
    .exception_code_wb (exception_code_wb),
    .retire_wb         (retire_wb)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] enc(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic alu_op_t arith_ref(input logic [2:0] f3, input logic [6:0] f7);
    case (f3)
      3'd0:    return ALU_OP_ADD;
      3'd1:    return ALU_OP_SLL;
      3'd2:    return ALU_OP_SLT;
      3'd3:    return ALU_OP_SLTU;
      3'd4:    return ALU_OP_XOR;
      3'd5:    return (f7 == FUNCT7_ALT) ? ALU_OP_SRA : ALU_OP_SRL;
      3'd6:    return ALU_OP_OR;
      default: return ALU_OP_AND;
    endcase
  endfunction

  // Expected ID controls of one word
  function automatic dec_t decode_ref(input logic [31:0] w);
    dec_t       d;
    logic [6:0] opc;
    logic [6:0] f7;
    logic [2:0] f3;
    opc = w[6:0];
    f3  = w[14:12];
    f7  = w[31:25];
    d = '0;
    d.rd       = w[11:7];
    d.rs1      = w[19:15];
    d.rs2      = w[24:20];
    d.dsize    = {1'b0, f3[1:0]};
    d.dtype    = f3;
    d.alu_op   = ALU_OP_SRCB;
    d.src_a    = SRC_A_RS1;
    d.src_b    = SRC_B_IMM;
    d.wb_src   = WB_SRC_MALU;
    d.imm      = IMM_I;
    d.uses_rs1 = !(opc == OPC_LUI || opc == OPC_AUIPC || opc == OPC_JAL);
    d.uses_rs2 = (opc == OPC_STORE || opc == OPC_BRANCH || opc == OPC_OP);
    case (opc)
      OPC_LOAD: begin
        d.alu_op  = ALU_OP_ADD;
        d.wb_src  = WB_SRC_MEM;
        d.dmem_en = 1'b1;
        d.wr_reg  = 1'b1;
      end
      OPC_STORE: begin
        d.alu_op   = ALU_OP_ADD;
        d.dmem_en  = 1'b1;
        d.dmem_wen = 1'b1;
        d.imm      = IMM_S;
      end
      OPC_BRANCH: begin
        d.src_b  = SRC_B_RS2;
        d.branch = 1'b1;
        case (f3)
          3'd0:    d.alu_op = ALU_OP_SEQ;
          3'd1:    d.alu_op = ALU_OP_SNE;
          3'd4:    d.alu_op = ALU_OP_SLT;
          3'd5:    d.alu_op = ALU_OP_SGE;
          3'd6:    d.alu_op = ALU_OP_SLTU;
          3'd7:    d.alu_op = ALU_OP_SGEU;
          default: d.illegal = 1'b1;
        endcase
      end
      OPC_JAL, OPC_JALR: begin
        d.alu_op  = ALU_OP_ADD;  // Link address
        d.src_a   = SRC_A_PC;
        d.src_b   = SRC_B_FOUR;
        d.wb_src  = WB_SRC_ALU;
        d.wr_reg  = 1'b1;
        d.jal     = (opc == OPC_JAL);
        d.jalr    = (opc == OPC_JALR);
        d.imm     = (opc == OPC_JAL) ? IMM_J : IMM_I;
        d.illegal = (opc == OPC_JALR) && (f3 != 3'd0);
      end
      OPC_MISC_MEM:
        d.illegal = (f3 != 3'd0) || (w[31:28] != 4'd0) || (w[19:15] != 5'd0) ||
                    (w[11:7] != 5'd0);
      OPC_OP_IMM, OPC_OP: begin
        d.wr_reg = 1'b1;
        d.alu_op = arith_ref(f3, f7);
        if (f3 == 3'd2 || f3 == 3'd3)
          d.wb_src = WB_SRC_ALU;
        if (opc == OPC_OP) begin
          d.src_b = SRC_B_RS2;
          if (f3 == 3'd0 && f7 == FUNCT7_ALT)
            d.alu_op = ALU_OP_SUB;
        end else if (f3 == 3'd0 && (w[19:15] == 5'd0 || w[31:20] == 12'd0)) begin
          d.alu_op = ALU_OP_XOR;  // Register move or load immediate
        end
      end
      OPC_AUIPC: begin
        d.alu_op = ALU_OP_ADD;
        d.src_a  = SRC_A_PC;
        d.wb_src = WB_SRC_ALU;
        d.wr_reg = 1'b1;
        d.imm    = IMM_U;
      end
      OPC_LUI: begin
        d.wr_reg = 1'b1;
        d.imm    = IMM_U;
      end
      default: d.illegal = 1'b1;
    endcase
    return d;
  endfunction

  // Legal word, rd in 1..15 and sources in 16..31 so nothing collides
  function automatic logic [31:0] rand_word();
    logic [31:0] r;
    logic [31:0] r2;
    logic [31:0] w;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    r   = $urandom;
    r2  = $urandom;
    rd  = (r[3:0] == 4'd0) ? 5'd1 : {1'b0, r[3:0]};
    rs1 = {1'b1, r[7:4]};
    rs2 = {1'b1, r[11:8]};
    f3  = r[14:12];
    f7  = r[15] ? FUNCT7_ALT : 7'd0;
    case (r[18:16] % 6)
      0: begin
        if (r[21:20] == 2'd0)
          rs1 = 5'd0;
        if (f3 == 3'd1 || f3 == 3'd5)
          w = enc(f7, rs2, rs1, f3, rd, OPC_OP_IMM);
        else
          w = {r2[31:20], rs1, f3, rd, OPC_OP_IMM};
      end
      1: w = enc(f7, rs2, rs1, f3, rd, OPC_OP);
      2: w = {r2[31:12], rd, OPC_LUI};
      3: w = {r2[31:12], rd, OPC_AUIPC};
      4: begin
        if (f3 == 3'd3 || f3 >= 3'd6)
          f3 = 3'd2;  // Keeps LB, LH, LW, LBU, LHU
        w = {r2[31:20], rs1, f3, rd, OPC_LOAD};
      end
      default: begin
        f3 = (f3[1:0] == 2'd3) ? 3'd0 : {1'b0, f3[1:0]};
        w  = {r2[31:25], rs2, rs1, f3, r2[4:0], OPC_STORE};
      end
    endcase
    return w;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("FAIL %0t ns %s expected %0h actual %0h", $time, name, exp, act);
    errors++;
  endtask

  // Compare process with the model pipeline
  always @(negedge clk) begin
    if (reset) begin
      ex_valid = 1'b0;
      ex_d     = '0;
      wb_valid = 1'b0;
      wb_wr    = 1'b0;
      wb_dmem  = 1'b0;
      wb_exc   = 1'b0;
      wb_rd    = 5'd0;
      wb_src   = WB_SRC_ALU;
    end else begin
      id_d       = decode_ref(inst_id);
      stall_wb_m = dmem_wait && wb_dmem;
      ex_exc_m   = ex_valid && ex_d.illegal;
      kill_ex_m  = stall_wb_m || ex_exc_m || wb_exc;
      taken_m    = ex_d.branch && cmp_true && !kill_ex_m;
      jal_m      = ex_d.jal && !kill_ex_m;
      jalr_m     = ex_d.jalr && !kill_ex_m;
      wr_ex_m    = ex_d.wr_reg && !kill_ex_m;
      hz1 = wr_ex_m && id_d.uses_rs1 && (id_d.rs1 == ex_d.rd) && (id_d.rs1 != 5'd0);
      hz2 = wr_ex_m && id_d.uses_rs2 && (id_d.rs2 == ex_d.rd) && (id_d.rs2 != 5'd0);
      exp_stall  = stall_wb_m || hz1 || hz2;
      exp_kill   = exp_stall || taken_m || jal_m || jalr_m || ex_exc_m || wb_exc;
      exp_wr     = wb_wr && !stall_wb_m;
      exp_retire = wb_valid && !stall_wb_m && !wb_exc;
      exp_byp1 = exp_wr && id_d.uses_rs1 && (id_d.rs1 == wb_rd) && (id_d.rs1 != 5'd0);
      exp_byp2 = exp_wr && id_d.uses_rs2 && (id_d.rs2 == wb_rd) && (id_d.rs2 != 5'd0);
      if (wb_exc)
        exp_pc = PC_HANDLER;
      else if (taken_m)
        exp_pc = PC_BRANCH_TARGET;
      else if (jal_m)
        exp_pc = PC_JAL_TARGET;
      else if (jalr_m)
        exp_pc = PC_JALR_TARGET;
      else
        exp_pc = PC_PLUS_FOUR;

      if (pc_src_sel !== exp_pc) report_mismatch("pc_src_sel", exp_pc, pc_src_sel);
      if (imm_type_id !== id_d.imm) report_mismatch("imm_type_id", id_d.imm, imm_type_id);
      if (stall_id !== exp_stall) report_mismatch("stall_id", exp_stall, stall_id);
      if (kill_id !== exp_kill) report_mismatch("kill_id", exp_kill, kill_id);
      if (bypass_rs1 !== exp_byp1) report_mismatch("bypass_rs1", exp_byp1, bypass_rs1);
      if (bypass_rs2 !== exp_byp2) report_mismatch("bypass_rs2", exp_byp2, bypass_rs2);
      if (dmem_en !== (ex_d.dmem_en && !kill_ex_m))
        report_mismatch("dmem_en", ex_d.dmem_en && !kill_ex_m, dmem_en);
      if (dmem_wen !== (ex_d.dmem_wen && !kill_ex_m))
        report_mismatch("dmem_wen", ex_d.dmem_wen && !kill_ex_m, dmem_wen);
      if (wr_reg_wb !== exp_wr) report_mismatch("wr_reg_wb", exp_wr, wr_reg_wb);
      if (exception_wb !== wb_exc) report_mismatch("exception_wb", wb_exc, exception_wb);
      if (retire_wb !== exp_retire) report_mismatch("retire_wb", exp_retire, retire_wb);
      if (wb_exc && exception_code_wb !== ECODE_ILLEGAL_INST)
        report_mismatch("exception_code_wb", ECODE_ILLEGAL_INST, exception_code_wb);
      if (ex_valid) begin
        if (alu_op_ex !== ex_d.alu_op) report_mismatch("alu_op_ex", ex_d.alu_op, alu_op_ex);
        if (src_a_sel_ex !== ex_d.src_a)
          report_mismatch("src_a_sel_ex", ex_d.src_a, src_a_sel_ex);
        if (src_b_sel_ex !== ex_d.src_b)
          report_mismatch("src_b_sel_ex", ex_d.src_b, src_b_sel_ex);
        if (dmem_size !== ex_d.dsize) report_mismatch("dmem_size", ex_d.dsize, dmem_size);
        if (dmem_type !== ex_d.dtype) report_mismatch("dmem_type", ex_d.dtype, dmem_type);
      end
      if (exp_wr) begin
        if (reg_to_wr_wb !== wb_rd) report_mismatch("reg_to_wr_wb", wb_rd, reg_to_wr_wb);
        if (wb_src_sel_wb !== wb_src) report_mismatch("wb_src_sel_wb", wb_src, wb_src_sel_wb);
      end
      if (wr_reg_wb && reg_to_wr_wb == KILLED_RD) begin
        $display("Killed instruction wrote back at %0t ns", $time);
        errors++;
      end

      if (stall_id && !dmem_wait) n_hazard++;
      if (stall_id && dmem_wait) n_mem_stall++;
      if (bypass_rs1) n_byp1++;
      if (bypass_rs2) n_byp2++;
      if (pc_src_sel == PC_BRANCH_TARGET) n_branch++;
      if (pc_src_sel == PC_JAL_TARGET) n_jal++;
      if (pc_src_sel == PC_JALR_TARGET) n_jalr++;
      if (exception_wb && exception_code_wb == ECODE_ILLEGAL_INST) n_trap++;
      if (retire_wb) n_retire++;

      // Advance to the next edge
      if (!stall_wb_m) begin
        wb_valid = ex_valid && !wb_exc;
        wb_wr    = wr_ex_m;
        wb_rd    = ex_d.rd;
        wb_src   = ex_d.wb_src;
        wb_dmem  = ex_d.dmem_en && !kill_ex_m;
        wb_exc   = ex_exc_m && !wb_exc;
        if (exp_kill) begin
          ex_valid      = 1'b0;
          ex_d.branch   = 1'b0;
          ex_d.jal      = 1'b0;
          ex_d.jalr     = 1'b0;
          ex_d.dmem_en  = 1'b0;
          ex_d.dmem_wen = 1'b0;
          ex_d.wr_reg   = 1'b0;
          ex_d.illegal  = 1'b0;
        end else begin
          ex_valid = 1'b1;
          ex_d     = id_d;
        end
      end
    end
  end

  task automatic end_run();
    $display("Errors: %0d, retired: %0d", errors, n_retire);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  endtask

  // Returns 1 ns after the edge that takes the word in ID
  task automatic wait_accept();
    int t;
    t = 0;
    @(negedge clk);
    while (stall_id && t < ACCEPT_LIMIT) begin
      t++;
      @(negedge clk);
    end
    if (stall_id) begin
      $display("Timeout: ID stayed stalled for %0d cycles", t);
      errors++;
      end_run();
    end else begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic send(input logic [31:0] w);
    inst_id = w;
    wait_accept();
  endtask

  task automatic require_seen(input string what, input int count);
    if (count == 0) begin
      $display("No %s seen during the run", what);
      errors++;
    end
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    inst_id     = NOP;
    dmem_wait   = 1'b0;
    cmp_true    = 1'b0;
    errors      = 0;
    n_hazard    = 0;
    n_mem_stall = 0;
    n_byp1      = 0;
    n_byp2      = 0;
    n_branch    = 0;
    n_jal       = 0;
    n_jalr      = 0;
    n_trap      = 0;
    n_retire    = 0;
    void'($urandom(14));
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    for (int i = 0; i < 60; i++)
      send(rand_word());
    send(enc(7'b0000111, 5'b11111, 5'd0, 3'd0, 5'd0, OPC_MISC_MEM));  // FENCE

    // RAW against EX, then bypass from WB
    send(enc(7'd0, 5'd17, 5'd16, 3'd0, 5'd5, OPC_OP));
    send(enc(7'd0, 5'd18, 5'd5, 3'd0, 5'd6, OPC_OP));
    send(enc(FUNCT7_ALT, 5'd6, 5'd19, 3'd0, 5'd7, OPC_OP));

    cmp_true = 1'b1;
    send(enc(7'd0, 5'd17, 5'd16, 3'd0, 5'd0, OPC_BRANCH));
    send(YOUNG);
    cmp_true = 1'b0;
    send(enc(7'd0, 5'd17, 5'd16, 3'd1, 5'd0, OPC_BRANCH));  // Not taken
    send(enc(7'd0, 5'd18, 5'd17, 3'd0, 5'd9, OPC_OP));
    send(enc(7'd0, 5'd8, 5'd0, 3'd0, 5'd1, OPC_JAL));
    send(YOUNG);
    send(enc(7'd0, 5'd0, 5'd20, 3'd0, 5'd1, OPC_JALR));
    send(YOUNG);

    // Illegal words, each followed by two younger ones
    send(SYSTEM_WORD);
    send(YOUNG);
    send(YOUNG);
    send(enc(7'd0, 5'd17, 5'd16, 3'd2, 5'd0, OPC_BRANCH));
    send(YOUNG);
    send(YOUNG);
    send(enc(7'd0, 5'd0, 5'd20, 3'd1, 5'd1, OPC_JALR));
    send(YOUNG);
    send(YOUNG);

    // Loads held in WB by the data memory
    for (int i = 0; i < 3; i++) begin
      send(enc(7'd0, 5'd4, 5'd16, 3'd2, 5'd10, OPC_LOAD));
      send(enc(7'd0, 5'd18, 5'd17, 3'd0, 5'd11, OPC_OP));
      inst_id   = enc(7'd0, 5'd19, 5'd17, 3'd0, 5'd12, OPC_OP);
      dmem_wait = 1'b1;
      repeat (1 + $urandom % 5) begin
        @(posedge clk);
        #1;
      end
      dmem_wait = 1'b0;
      wait_accept();
    end

    repeat (3) send(NOP);

    require_seen("hazard stall", n_hazard);
    require_seen("memory stall", n_mem_stall);
    require_seen("rs1 bypass", n_byp1);
    require_seen("rs2 bypass", n_byp2);
    require_seen("taken branch", n_branch);
    require_seen("JAL redirect", n_jal);
    require_seen("JALR redirect", n_jalr);
    require_seen("illegal-instruction trap", n_trap);
    require_seen("retired instruction", n_retire);
    end_run();
  end

endmodule

//--- all.f
src/ctrl_pkg.sv
src/id_ctrl_if.sv
src/ex_ctrl_if.sv
src/instr_decoder.sv
src/id_ex_ctrl_reg.sv
src/ex_wb_ctrl.sv
src/pipeline_ctrl.sv
testbench/pipeline_ctrl_tb.sv

//--- Bender.yml
package:
  name: pipeline_ctrl

sources:
  - src/ctrl_pkg.sv
  - src/id_ctrl_if.sv
  - src/ex_ctrl_if.sv
  - src/instr_decoder.sv
  - src/id_ex_ctrl_reg.sv
  - src/ex_wb_ctrl.sv
  - src/pipeline_ctrl.sv
  - target: test
    files:
      - testbench/pipeline_ctrl_tb.sv
